//--- compile.f
+incdir+sim
src/ooo_int_pkg.sv
src/dispatch_stage.sv
src/scoreboard_int.sv
src/issue_queue_int.sv
src/prf_int.sv
src/int_alu_pipe.sv
src/int_issue_slice.sv
sim/tb_int_issue_slice.sv

//--- run_sim.sh
#!/bin/sh
# Build the integer issue slice testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_int_issue_slice -o tb_int_issue_slice \
  && ./obj_dir/tb_int_issue_slice | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

//--- sim/tb_uop_table.svh
/*
 * Micro-op stimulus table with LCG immediates
 * Typed compare tasks for writeback results and flags
 */

`ifndef TB_UOP_TABLE_SVH
`define TB_UOP_TABLE_SVH

int_uop_t    uop_table [NUM_UOPS];
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic set_row(input int idx, input alu_op_t op, input int rd, input int rs1,
                       input int rs2);
  uop_table[idx].op  = op;
  uop_table[idx].rd  = preg_t'(rd);
  uop_table[idx].rs1 = preg_t'(rs1);
  uop_table[idx].rs2 = preg_t'(rs2);
  uop_table[idx].imm = '0;
  uop_table[idx].tag = rob_tag_t'(idx % 16);
  if (op == OP_LI) begin
    lcg_state          = lcg_next(lcg_state);
    uop_table[idx].imm = lcg_state;
  end
endtask

task automatic build_table();
  lcg_state = 32'h85f3_faa4;
  // Short li/add/sub/xor chain feeding a mul
  set_row(0, OP_LI, 1, 0, 0);
  set_row(1, OP_LI, 2, 0, 0);
  set_row(2, OP_ADD, 3, 1, 2);
  set_row(3, OP_SUB, 4, 3, 1);
  set_row(4, OP_XOR, 5, 4, 2);
  set_row(5, OP_LI, 6, 0, 0);
  set_row(6, OP_MUL, 7, 5, 6);
  set_row(7, OP_ADD, 8, 0, 0);
  set_row(8, OP_XOR, 9, 7, 3);
  // mul 10 and add 12 should finish together
  set_row(9, OP_LI, 10, 0, 0);
  set_row(10, OP_MUL, 11, 10, 1);
  set_row(11, OP_LI, 12, 0, 0);
  set_row(12, OP_ADD, 13, 12, 12);
  set_row(13, OP_LI, 14, 0, 0);
  set_row(14, OP_SUB, 15, 14, 13);
  set_row(15, OP_XOR, 16, 0, 0);
  set_row(16, OP_ADD, 17, 11, 0);
  set_row(17, OP_LI, 18, 0, 0);
  set_row(18, OP_MUL, 19, 18, 17);
  set_row(19, OP_SUB, 20, 19, 9);
  // Eight dependent muls back up the queue
  set_row(20, OP_MUL, 21, 20, 18);
  set_row(21, OP_MUL, 22, 21, 21);
  set_row(22, OP_MUL, 23, 22, 18);
  set_row(23, OP_MUL, 24, 23, 17);
  set_row(24, OP_MUL, 25, 24, 24);
  set_row(25, OP_MUL, 26, 25, 6);
  set_row(26, OP_MUL, 27, 26, 10);
  set_row(27, OP_MUL, 28, 27, 12);
  set_row(28, OP_ADD, 29, 28, 20);
  set_row(29, OP_XOR, 30, 29, 28);
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
  if (act !== exp) begin
    report_failure($sformatf("Mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act));
  end
endtask

task automatic check_tag(input string name, input rob_tag_t exp, input rob_tag_t act);
  if (act !== exp) begin
    report_failure($sformatf("Mismatch %s: expected 0x%01h, got 0x%01h", name, exp, act));
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    report_failure($sformatf("Mismatch %s: expected 0x%01h, got 0x%01h", name, exp, act));
  end
endtask

`endif

//--- sim/tb_int_issue_slice.sv
/*
 * Testbench for the integer issue slice
 * Clock, reset, table-driven stimulus, reference model,
 * writeback monitor and watchdog
 */

module tb_int_issue_slice
  import ooo_int_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_UOPS        = 30;
  localparam int CLK_PERIOD      = 40;
  localparam int WATCHDOG_CYCLES = NUM_UOPS * 40;

  logic                      clock;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_ready;
  int_uop_t                  in_uop;
  wb_t [PRF_INT_WAYS-1:0]    wb;

  data_t expected_value [NUM_UOPS];
  logic  seen [NUM_UOPS];
  int    seen_count;
  logic  saw_stall;
  logic  saw_dual;

  `include "tb_uop_table.svh"

  int_issue_slice u_dut (
    .clock, .rst_n, .in_valid, .in_ready, .in_uop, .wb
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  // Program-order execution of the table, p0 is never written
  task automatic compute_expected();
    data_t ref_regs [PRF_INT_SIZE];
    data_t a;
    data_t b;
    for (int r = 0; r < PRF_INT_SIZE; r++) begin
      ref_regs[r] = '0;
    end
    for (int i = 0; i < NUM_UOPS; i++) begin
      a = ref_regs[uop_table[i].rs1];
      b = ref_regs[uop_table[i].rs2];
      case (uop_table[i].op)
        OP_LI:   expected_value[i] = uop_table[i].imm;
        OP_ADD:  expected_value[i] = a + b;
        OP_SUB:  expected_value[i] = a - b;
        OP_XOR:  expected_value[i] = a ^ b;
        OP_MUL:  expected_value[i] = a * b;
        default: expected_value[i] = '0;
      endcase
      ref_regs[uop_table[i].rd] = expected_value[i];
    end
  endtask

  // Table entry that owns this destination, every rd in the table is unique
  function automatic int find_entry(input preg_t rd);
    int idx;
    idx = -1;
    for (int i = 0; i < NUM_UOPS; i++) begin
      if (uop_table[i].rd == rd) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic int expected_way(input alu_op_t op);
    return (op == OP_MUL) ? 1 : 0;
  endfunction

  task automatic drive_uop(input int_uop_t uop);
    @(negedge clock);
    in_valid = 1'b1;
    in_uop   = uop;
    while (!in_ready) begin
      saw_stall = 1'b1;
      @(negedge clock);
    end
  endtask

  always @(negedge clock) begin : wb_monitor
    int idx;
    if (rst_n) begin
      if (wb[0].valid && wb[1].valid) begin
        saw_dual = 1'b1;
      end
      for (int j = 0; j < PRF_INT_WAYS; j++) begin
        if (wb[j].valid) begin
          idx = find_entry(wb[j].rd);
          if (idx < 0) begin
            report_failure($sformatf("wb[%0d] wrote rd 0x%02h which no table entry targets",
                                     j, wb[j].rd));
          end else if (seen[idx]) begin
            report_failure($sformatf("wb[%0d] reported entry %0d a second time", j, idx));
          end else if (j != expected_way(uop_table[idx].op)) begin
            report_failure($sformatf("entry %0d came back on way %0d instead of way %0d",
                                     idx, j, expected_way(uop_table[idx].op)));
          end else begin
            check_tag($sformatf("wb[%0d].tag", j), uop_table[idx].tag, wb[j].tag);
            check_data($sformatf("wb[%0d].value", j), expected_value[idx], wb[j].value);
            seen[idx]  = 1'b1;
            seen_count = seen_count + 1;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure($sformatf("Timeout after %0d cycles with %0d of %0d results seen",
                             WATCHDOG_CYCLES, seen_count, NUM_UOPS));
  end

  initial begin : stimulus
    clock      = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_uop     = '0;
    seen_count = 0;
    saw_stall  = 1'b0;
    saw_dual   = 1'b0;
    for (int i = 0; i < NUM_UOPS; i++) begin
      seen[i] = 1'b0;
    end
    build_table();
    compute_expected();

    repeat (5) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;

    // Idle slice after reset
    repeat (4) begin
      @(negedge clock);
      check_flag("in_ready", 1'b1, in_ready);
      check_flag("wb[0].valid", 1'b0, wb[0].valid);
      check_flag("wb[1].valid", 1'b0, wb[1].valid);
    end

    for (int i = 0; i < NUM_UOPS; i++) begin
      drive_uop(uop_table[i]);
    end
    @(negedge clock);
    in_valid = 1'b0;
    in_uop   = '0;

    wait (seen_count == NUM_UOPS);
    // Late duplicates would show up here
    repeat (10) @(negedge clock);

    if (!saw_stall) begin
      report_failure("in_ready never dropped while the mul chain filled the queue");
    end else if (!saw_dual) begin
      report_failure("no cycle had a fast result and a mul result together");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- src/dispatch_stage.sv
/*
 * Dispatch register with valid/ready input handshake
 * Back-pressure from issue queue occupancy
 */

module dispatch_stage
  import ooo_int_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  int_uop_t                     in_uop,
  input  logic [$clog2(IQ_INT_SIZE):0] iq_count,
  output logic                         disp_valid,
  output int_uop_t                     disp_uop
);

  logic [$clog2(IQ_INT_SIZE):0] occupancy;
  logic                         accept;

  // Entries in the queue plus the one held here
  assign occupancy = iq_count + {{$clog2(IQ_INT_SIZE){1'b0}}, disp_valid};
  assign in_ready  = occupancy < IQ_INT_SIZE;
  assign accept    = in_valid && in_ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      disp_valid <= 1'b0;
    end else begin
      disp_valid <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      disp_uop <= in_uop;
    end
  end

  // Source must hold a stalled micro-op until it is taken
  a_src_hold: assert property (
    @(posedge clock) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_uop)
  ) else $error("dispatch: source changed a stalled micro-op");

  // Counted space never exceeds the queue depth
  a_no_overflow: assert property (
    @(posedge clock) disable iff (!rst_n)
    occupancy <= IQ_INT_SIZE
  ) else $error("dispatch: occupancy above queue depth");

endmodule

//--- src/int_alu_pipe.sv
/*
 * Operand latch, fast ALU pipe (way 0) and mul pipe (way 1)
 */

module int_alu_pipe
  import ooo_int_pkg::*;
(
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     iss_valid,
  input  int_uop_t                 iss_uop,
  output preg_t                    raddr1,
  output preg_t                    raddr2,
  input  data_t                    rdata1,
  input  data_t                    rdata2,
  output wb_t [PRF_INT_WAYS-1:0]   wb
);

  logic     ex_valid;
  int_uop_t ex_uop;
  data_t    fast_value;
  wb_t      fast_q;
  wb_t      slow_q [SLOW_LATENCY];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= iss_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (iss_valid) begin
      ex_uop <= iss_uop;
    end
  end

  // Operand read happens in the execute cycle
  assign raddr1 = ex_uop.rs1;
  assign raddr2 = ex_uop.rs2;

  always_comb begin
    case (ex_uop.op)
      OP_LI:   fast_value = ex_uop.imm;
      OP_ADD:  fast_value = rdata1 + rdata2;
      OP_SUB:  fast_value = rdata1 - rdata2;
      OP_XOR:  fast_value = rdata1 ^ rdata2;
      default: fast_value = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fast_q <= '0;
      for (int k = 0; k < SLOW_LATENCY; k++) begin
        slow_q[k] <= '0;
      end
    end else begin
      fast_q <= '{valid: ex_valid && (ex_uop.op != OP_MUL), rd: ex_uop.rd,
                  value: fast_value, tag: ex_uop.tag};
      // Low half of the product enters the first mul stage
      slow_q[0] <= '{valid: ex_valid && (ex_uop.op == OP_MUL), rd: ex_uop.rd,
                     value: data_t'(rdata1 * rdata2), tag: ex_uop.tag};
      for (int k = 1; k < SLOW_LATENCY; k++) begin
        slow_q[k] <= slow_q[k-1];
      end
    end
  end

  assign wb[0] = fast_q;
  assign wb[1] = slow_q[SLOW_LATENCY-1];

endmodule

//--- src/int_issue_slice.sv
/*
 * Top of the integer issue slice
 * Dispatch, scoreboard, issue queue, PRF and execution pipes
 */

module int_issue_slice
  import ooo_int_pkg::*;
(
  input  logic                     clock,
  input  logic                     rst_n,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  int_uop_t                 in_uop,
  output wb_t [PRF_INT_WAYS-1:0]   wb
);

  logic                         disp_valid;
  int_uop_t                     disp_uop;
  logic [$clog2(IQ_INT_SIZE):0] iq_count;
  preg_t [IQ_INT_SIZE-1:0]      rs1_index;
  preg_t [IQ_INT_SIZE-1:0]      rs2_index;
  logic  [IQ_INT_SIZE-1:0]      rs1_busy;
  logic  [IQ_INT_SIZE-1:0]      rs2_busy;
  logic                         iss_valid;
  int_uop_t                     iss_uop;
  preg_t                        raddr1;
  preg_t                        raddr2;
  data_t                        rdata1;
  data_t                        rdata2;

  dispatch_stage u_dispatch (
    .clock, .rst_n, .in_valid, .in_ready, .in_uop, .iq_count, .disp_valid, .disp_uop
  );

  scoreboard_int u_scoreboard (
    .clock, .rst_n, .set_valid(disp_valid), .set_index(disp_uop.rd), .wb,
    .rs1_index, .rs2_index, .rs1_busy, .rs2_busy
  );

  issue_queue_int u_issue_queue (
    .clock, .rst_n, .disp_valid, .disp_uop, .iq_count, .rs1_index, .rs2_index,
    .rs1_busy, .rs2_busy, .iss_valid, .iss_uop
  );

  prf_int u_prf (
    .clock, .rst_n, .raddr1, .raddr2, .rdata1, .rdata2, .wb
  );

  int_alu_pipe u_alu_pipe (
    .clock, .rst_n, .iss_valid, .iss_uop, .raddr1, .raddr2, .rdata1, .rdata2, .wb
  );

endmodule

//--- src/issue_queue_int.sv
/*
 * Eight-entry age-ordered integer issue queue
 * Compacted toward slot 0, oldest-ready select, registered issue
 */

module issue_queue_int
  import ooo_int_pkg::*;
(
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         disp_valid,
  input  int_uop_t                     disp_uop,
  output logic [$clog2(IQ_INT_SIZE):0] iq_count,
  output preg_t [IQ_INT_SIZE-1:0]      rs1_index,
  output preg_t [IQ_INT_SIZE-1:0]      rs2_index,
  input  logic  [IQ_INT_SIZE-1:0]      rs1_busy,
  input  logic  [IQ_INT_SIZE-1:0]      rs2_busy,
  output logic                         iss_valid,
  output int_uop_t                     iss_uop
);

  logic     [IQ_INT_SIZE-1:0]           q_valid;
  int_uop_t                             q_uop [IQ_INT_SIZE];
  logic     [IQ_INT_SIZE-1:0]           nxt_valid;
  int_uop_t                             nxt_uop [IQ_INT_SIZE];
  logic     [IQ_INT_SIZE-1:0]           ready;
  logic                                 sel_found;
  logic     [$clog2(IQ_INT_SIZE)-1:0]   sel_idx;
  logic     [$clog2(IQ_INT_SIZE):0]     tail;

  assign iq_count = $bits(iq_count)'($countones(q_valid));

  // Source lookups go to the scoreboard for every slot
  always_comb begin
    for (int i = 0; i < IQ_INT_SIZE; i++) begin
      rs1_index[i] = q_uop[i].rs1;
      rs2_index[i] = q_uop[i].rs2;
    end
  end

  assign ready = q_valid & ~rs1_busy & ~rs2_busy;

  // Lowest ready slot is the oldest
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = IQ_INT_SIZE - 1; i >= 0; i--) begin
      if (ready[i]) begin
        sel_found = 1'b1;
        sel_idx   = i[$clog2(IQ_INT_SIZE)-1:0];
      end
    end
  end

  // First free slot once the issued entry has been squeezed out
  assign tail = iq_count - {{$clog2(IQ_INT_SIZE){1'b0}}, sel_found};

  always_comb begin
    nxt_valid = q_valid;
    for (int i = 0; i < IQ_INT_SIZE; i++) begin
      nxt_uop[i] = q_uop[i];
    end

    // Younger entries move down by one behind the issued slot
    if (sel_found) begin
      for (int i = 0; i < IQ_INT_SIZE; i++) begin
        if (i >= sel_idx) begin
          if (i < IQ_INT_SIZE - 1) begin
            nxt_valid[i] = q_valid[i+1];
            nxt_uop[i]   = q_uop[i+1];
          end else begin
            nxt_valid[i] = 1'b0;
          end
        end
      end
    end

    // New entry is the youngest
    for (int i = 0; i < IQ_INT_SIZE; i++) begin
      if (disp_valid && (i == tail)) begin
        nxt_valid[i] = 1'b1;
        nxt_uop[i]   = disp_uop;
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      q_valid   <= '0;
      iss_valid <= 1'b0;
    end else begin
      q_valid   <= nxt_valid;
      iss_valid <= sel_found;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < IQ_INT_SIZE; i++) begin
      q_uop[i] <= nxt_uop[i];
    end
    if (sel_found) begin
      iss_uop <= q_uop[sel_idx];
    end
  end

  // Dispatch reserves its slot ahead of time
  a_no_disp_when_full: assert property (
    @(posedge clock) disable iff (!rst_n)
    disp_valid |-> iq_count < IQ_INT_SIZE
  ) else $error("issue queue: dispatch into a full queue");

endmodule

//--- src/ooo_int_pkg.sv
/*
 * Shared sizes, vector typedefs, ALU op encoding and the
 * micro-op and writeback structs of the integer issue slice
 */

package ooo_int_pkg;

  // Physical register file
  localparam int PRF_INT_SIZE       = 32;
  localparam int PRF_INT_INDEX_SIZE = 5;
  localparam int PRF_INT_WAYS       = 2;

  // Issue queue depth
  localparam int IQ_INT_SIZE = 8;

  localparam int XLEN         = 32;
  localparam int SLOW_LATENCY = 3;
  localparam int ROB_TAG_SIZE = 4;

  typedef logic [PRF_INT_INDEX_SIZE-1:0] preg_t;
  typedef logic [XLEN-1:0]               data_t;
  typedef logic [ROB_TAG_SIZE-1:0]       rob_tag_t;

  typedef enum logic [2:0] {
    OP_LI,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_MUL
  } alu_op_t;

  // Renamed micro-op, imm only meaningful for OP_LI
  typedef struct packed {
    alu_op_t  op;
    preg_t    rd;
    preg_t    rs1;
    preg_t    rs2;
    data_t    imm;
    rob_tag_t tag;
  } int_uop_t;

  // One writeback way, way 0 fast and way 1 slow
  typedef struct packed {
    logic     valid;
    preg_t    rd;
    data_t    value;
    rob_tag_t tag;
  } wb_t;

endpackage

//--- src/prf_int.sv
/*
 * Integer physical register file, 32 x 32
 * Two async read ports, two writeback write ports, p0 reads zero
 */

module prf_int
  import ooo_int_pkg::*;
(
  input  logic                     clock,
  input  logic                     rst_n,
  input  preg_t                    raddr1,
  input  preg_t                    raddr2,
  output data_t                    rdata1,
  output data_t                    rdata2,
  input  wb_t [PRF_INT_WAYS-1:0]   wb
);

  data_t regs [PRF_INT_SIZE];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < PRF_INT_SIZE; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int j = 0; j < PRF_INT_WAYS; j++) begin
        if (wb[j].valid && (wb[j].rd != '0)) begin
          regs[wb[j].rd] <= wb[j].value;
        end
      end
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // Renaming gives each in-flight result its own register
  a_no_way_conflict: assert property (
    @(posedge clock) disable iff (!rst_n)
    wb[0].valid && wb[1].valid |-> wb[0].rd != wb[1].rd
  ) else $error("prf: both ways write the same register");

endmodule

//--- src/scoreboard_int.sv
/*
 * Integer scoreboard with one busy bit per physical register
 * Per-slot source lookup with p0 rule and writeback bypass
 */

module scoreboard_int
  import ooo_int_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              set_valid,
  input  preg_t                             set_index,
  input  wb_t   [PRF_INT_WAYS-1:0]          wb,
  input  preg_t [IQ_INT_SIZE-1:0]           rs1_index,
  input  preg_t [IQ_INT_SIZE-1:0]           rs2_index,
  output logic  [IQ_INT_SIZE-1:0]           rs1_busy,
  output logic  [IQ_INT_SIZE-1:0]           rs2_busy
);

  logic [PRF_INT_SIZE-1:0] busy;
  logic [PRF_INT_SIZE-1:0] set_req;
  logic [PRF_INT_SIZE-1:0] clear_req;

  always_comb begin
    set_req = '0;
    if (set_valid) begin
      set_req[set_index] = 1'b1;
    end
  end

  always_comb begin
    clear_req = '0;
    for (int j = 0; j < PRF_INT_WAYS; j++) begin
      if (wb[j].valid) begin
        clear_req[wb[j].rd] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      busy <= (busy | set_req) & ~clear_req;
    end
  end

  // p0 is never busy, a writeback this cycle wakes the source up
  always_comb begin
    for (int i = 0; i < IQ_INT_SIZE; i++) begin
      rs1_busy[i] = (rs1_index[i] != '0) && busy[rs1_index[i]];
      rs2_busy[i] = (rs2_index[i] != '0) && busy[rs2_index[i]];
      for (int j = 0; j < PRF_INT_WAYS; j++) begin
        if (wb[j].valid && (wb[j].rd == rs1_index[i])) begin
          rs1_busy[i] = 1'b0;
        end
        if (wb[j].valid && (wb[j].rd == rs2_index[i])) begin
          rs2_busy[i] = 1'b0;
        end
      end
    end
  end

  a_set_not_p0: assert property (
    @(posedge clock) disable iff (!rst_n)
    set_valid |-> set_index != '0
  ) else $error("scoreboard: busy set on p0");

  // A new destination must have been released by its previous writer
  a_set_free: assert property (
    @(posedge clock) disable iff (!rst_n)
    set_valid |-> !busy[set_index]
  ) else $error("scoreboard: busy set on a register already busy");

endmodule
